// ==== Bender.yml ====
package:
  name: port_switch

sources:
  - src/switch_pkg.sv
  - src/port_rx.sv
  - src/buf_arbiter.sv
  - src/packet_buffer.sv
  - src/packet_reader.sv
  - src/port_switch_top.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_port_switch.sv

// ==== compile.f ====
src/switch_pkg.sv
src/port_rx.sv
src/buf_arbiter.sv
src/packet_buffer.sv
src/packet_reader.sv
src/port_switch_top.sv
tb/tb_clock_gen.sv
tb/tb_port_switch.sv

// ==== src/buf_arbiter.sv ====
`timescale 1ns/1ps

module buf_arbiter #(
    parameter int NUM_PORTS = switch_pkg::NUM_PORTS
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [NUM_PORTS-1:0] req,
    input  switch_pkg::wr_req_t  wr_in [NUM_PORTS],
    output logic [NUM_PORTS-1:0] gnt,
    output switch_pkg::wr_req_t  wr_out
);

    localparam int PW = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

    logic [PW-1:0] ptr;
    logic [PW-1:0] win;
    logic          found;

    always_comb
    begin
        int idx;
        gnt   = '0;
        win   = '0;
        found = 1'b0;
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            idx = (int'(ptr) + i) % NUM_PORTS;               // search from pointer
            if (!found && req[idx])
            begin
                found    = 1'b1;
                win      = PW'(idx);
                gnt[idx] = 1'b1;
            end
        end
        wr_out       = wr_in[win];
        wr_out.valid = found;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            ptr <= '0;
        else if (found)
            ptr <= (int'(win) == NUM_PORTS - 1) ? '0 : win + 1'b1;
    end

    a_gnt_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(gnt));

endmodule

// ==== src/packet_buffer.sv ====
`timescale 1ns/1ps

module packet_buffer #(
    parameter int NUM_SLOTS    = switch_pkg::NUM_SLOTS,
    parameter int SLOT_ENTRIES = switch_pkg::SLOT_ENTRIES
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [switch_pkg::NUM_PORTS-1:0] slot_req,
    output logic [switch_pkg::NUM_PORTS-1:0] slot_ok,
    output logic [switch_pkg::SLOT_W-1:0]    slot_id,
    input  switch_pkg::wr_req_t              wr,
    input  logic                             desc_pop,
    output switch_pkg::desc_t                desc,
    output logic                             desc_empty,
    input  logic [switch_pkg::SLOT_W-1:0]    rd_slot,
    input  logic [switch_pkg::ENTRY_W-1:0]   rd_entry,
    output logic [31:0]                      rd_data,
    input  logic                             slot_free,
    input  logic [switch_pkg::SLOT_W-1:0]    slot_free_id
);

    localparam int CW = $clog2(NUM_SLOTS + 1);

    logic [31:0]                      mem [NUM_SLOTS * SLOT_ENTRIES];
    logic [switch_pkg::SLOT_W-1:0]    free_mem [NUM_SLOTS];
    switch_pkg::desc_t                dq_mem [NUM_SLOTS];
    logic [switch_pkg::SLOT_W-1:0]    fl_rd;
    logic [switch_pkg::SLOT_W-1:0]    fl_wr;
    logic [CW-1:0]                    fl_cnt;
    logic [switch_pkg::SLOT_W-1:0]    dq_rd;
    logic [switch_pkg::SLOT_W-1:0]    dq_wr;
    logic [CW-1:0]                    dq_cnt;
    logic [switch_pkg::NUM_PORTS-1:0] pend_q;
    logic [switch_pkg::NUM_PORTS-1:0] pend;
    logic [switch_pkg::NUM_PORTS-1:0] serve;
    logic                             fl_pop;
    logic                             dq_push;
    logic                             dq_pop;

    function automatic logic [switch_pkg::SLOT_W-1:0] wrap_inc(
        input logic [switch_pkg::SLOT_W-1:0] p
    );
        return (int'(p) == NUM_SLOTS - 1) ? '0 : p + 1'b1;
    endfunction

    assign pend    = pend_q | slot_req;
    assign serve   = pend & (~pend + 1'b1);                 // lowest port first
    assign fl_pop  = (|serve) && (fl_cnt != '0);
    assign dq_push = wr.valid && wr.last;
    assign dq_pop  = desc_pop && !desc_empty;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pend_q  <= '0;
            slot_ok <= '0;
            fl_rd   <= '0;
            fl_wr   <= '0;
            fl_cnt  <= CW'(NUM_SLOTS);
            dq_rd   <= '0;
            dq_wr   <= '0;
            dq_cnt  <= '0;
            for (int i = 0; i < NUM_SLOTS; i++)
                free_mem[i] <= switch_pkg::SLOT_W'(i);   // every slot starts free
        end
        else
        begin
            pend_q  <= pend & ~serve;
            slot_ok <= fl_pop ? serve : '0;              // empty list, no strobe
            if (fl_pop)
                fl_rd <= wrap_inc(fl_rd);
            if (slot_free)
            begin
                free_mem[fl_wr] <= slot_free_id;
                fl_wr           <= wrap_inc(fl_wr);
            end
            fl_cnt <= fl_cnt + CW'(slot_free) - CW'(fl_pop);
            if (dq_push)
                dq_wr <= wrap_inc(dq_wr);
            if (dq_pop)
                dq_rd <= wrap_inc(dq_rd);
            dq_cnt <= dq_cnt + CW'(dq_push) - CW'(dq_pop);
        end
    end

    always_ff @(posedge clk)
    begin
        if (fl_pop)
            slot_id <= free_mem[fl_rd];
        if (dq_push)
        begin
            dq_mem[dq_wr].slot <= wr.slot;
            dq_mem[dq_wr].hdr  <= wr.hdr;
            dq_mem[dq_wr].src  <= wr.src;
        end
        if (wr.valid)
            mem[int'(wr.slot) * SLOT_ENTRIES + int'(wr.entry)] <=
                wr.two_words ? wr.data : {16'h0000, wr.data[15:0]};
        rd_data <= mem[int'(rd_slot) * SLOT_ENTRIES + int'(rd_entry)];
    end

    assign desc       = dq_mem[dq_rd];
    assign desc_empty = (dq_cnt == '0);

    a_free_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        slot_free |-> (fl_cnt < CW'(NUM_SLOTS)));

endmodule

// ==== src/packet_reader.sv ====
`timescale 1ns/1ps

module packet_reader #(
    parameter int NUM_SLOTS    = switch_pkg::NUM_SLOTS,
    parameter int SLOT_ENTRIES = switch_pkg::SLOT_ENTRIES
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           desc_empty,
    input  switch_pkg::desc_t              desc,
    output logic                           desc_pop,
    output logic [switch_pkg::SLOT_W-1:0]  rd_slot,
    output logic [switch_pkg::ENTRY_W-1:0] rd_entry,
    input  logic [31:0]                    rd_data,
    output logic                           slot_free,
    output logic [switch_pkg::SLOT_W-1:0]  slot_free_id,
    input  logic                           xfer_stop,
    output logic [15:0]                    data,
    output logic [3:0]                     dest_port,
    output logic [8:0]                     length,
    output logic [2:0]                     prio,
    output logic [switch_pkg::PORT_W-1:0]  src_port,
    output logic                           data_vld,
    output logic                           sop_out,
    output logic                           eop_out
);

    localparam logic [1:0] IDLE   = 2'd0;
    localparam logic [1:0] FETCH  = 2'd1;
    localparam logic [1:0] STREAM = 2'd2;

    logic [1:0]        state;
    switch_pkg::desc_t cur;
    logic [8:0]        widx;
    logic [8:0]        nxt_widx;
    logic              advance;
    logic              last;

    assign desc_pop = (state == IDLE) && !desc_empty;
    assign advance  = (state == STREAM) && !xfer_stop;    // freeze on stall
    assign last     = (widx == cur.hdr.length - 9'd1);
    assign nxt_widx = widx + 9'(advance);

    // address the entry needed on the next cycle
    assign rd_slot  = cur.slot;
    assign rd_entry = nxt_widx[switch_pkg::ENTRY_W:1];

    assign data         = widx[0] ? rd_data[31:16] : rd_data[15:0];
    assign data_vld     = advance;
    assign sop_out      = advance && (widx == 9'd0);
    assign eop_out      = advance && last;
    assign slot_free    = eop_out;
    assign slot_free_id = cur.slot;
    assign dest_port    = cur.hdr.dest;
    assign length       = cur.hdr.length;
    assign prio         = cur.hdr.prio;
    assign src_port     = cur.src;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= IDLE;
            widx  <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    widx <= '0;
                    if (!desc_empty)
                        state <= FETCH;
                end
                FETCH:
                    state <= STREAM;
                STREAM:
                begin
                    widx <= nxt_widx;
                    if (advance && last)
                        state <= IDLE;
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (desc_pop)
            cur <= desc;
    end

    a_desc_fits: assert property (@(posedge clk) disable iff (!rst_n)
        (state == FETCH) |->
            (cur.hdr.length <= 9'(2 * SLOT_ENTRIES)) && (int'(cur.slot) < NUM_SLOTS));

endmodule

// ==== src/port_rx.sv ====
`timescale 1ns/1ps

module port_rx #(
    parameter int PORT_ID = 0
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          wr_sop,
    input  logic                          wr_eop,
    input  logic                          wr_vld,
    input  logic [15:0]                   wr_data,
    output logic                          slot_req,
    input  logic                          slot_ok,
    input  logic [switch_pkg::SLOT_W-1:0] slot_id,
    output logic                          req,
    output switch_pkg::wr_req_t           wr,
    input  logic                          gnt,
    output logic [7:0]                    drop_cnt
);

    localparam logic [switch_pkg::PORT_W-1:0] SRC = switch_pkg::PORT_W'(PORT_ID);

    switch_pkg::rx_word_u          word;
    switch_pkg::hdr_t              cur_hdr;
    switch_pkg::wr_req_t           pair_q;
    switch_pkg::wr_req_t           push_req;
    switch_pkg::wr_req_t           fifo [4];
    logic [switch_pkg::SLOT_W-1:0] cur_slot;
    logic [switch_pkg::PORT_W-1:0] wait_cnt;
    logic [15:0]                   lo_q;
    logic [8:0]                    cnt;
    logic [1:0]                    wr_ptr;
    logic [1:0]                    rd_ptr;
    logic [2:0]                    fifo_cnt;
    logic                          expect_hdr;
    logic                          in_pkt;
    logic                          waiting;
    logic                          drop_q;
    logic                          hdr_now;
    logic                          pay_now;
    logic                          last_word;
    logic                          deny_now;
    logic                          push;

    assign word      = wr_data;
    assign hdr_now   = wr_vld && (expect_hdr || wr_sop);
    assign pay_now   = wr_vld && in_pkt && !hdr_now;
    assign last_word = (cnt == cur_hdr.length - 9'd1);
    assign slot_req  = hdr_now && (word.hdr.length != 9'd0);

    // lower ports are served first, so port n hears back within n+1 cycles
    assign deny_now = waiting && !slot_ok && (wait_cnt == SRC);
    assign push     = pair_q.valid && !drop_q && !deny_now;

    always_comb
    begin
        push_req      = pair_q;
        push_req.slot = (waiting && slot_ok) ? slot_id : cur_slot;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            expect_hdr <= 1'b0;
            in_pkt     <= 1'b0;
            cnt        <= '0;
            waiting    <= 1'b0;
            wait_cnt   <= '0;
            drop_q     <= 1'b0;
            drop_cnt   <= '0;
            pair_q     <= '0;
        end
        else
        begin
            pair_q.valid <= 1'b0;
            if (waiting)
            begin
                wait_cnt <= wait_cnt + 1'b1;
                if (slot_ok)
                    waiting <= 1'b0;
                else if (deny_now)
                begin
                    waiting  <= 1'b0;
                    drop_q   <= 1'b1;
                    drop_cnt <= drop_cnt + 8'd1;
                end
            end
            if (hdr_now)
            begin
                expect_hdr <= 1'b0;
                in_pkt     <= slot_req;
                cnt        <= '0;
                drop_q     <= 1'b0;
                waiting    <= slot_req;
                wait_cnt   <= '0;
            end
            else
            begin
                if (wr_sop)
                    expect_hdr <= 1'b1;
                if (pay_now)
                    cnt <= cnt + 9'd1;
                if (wr_eop || (pay_now && last_word))
                    in_pkt <= 1'b0;
            end
            if (pay_now && (cnt[0] || last_word))
            begin
                pair_q.valid     <= 1'b1;
                pair_q.entry     <= cnt[switch_pkg::ENTRY_W:1];
                pair_q.data      <= cnt[0] ? {word.raw, lo_q} : {16'h0000, word.raw};
                pair_q.two_words <= cnt[0];                // odd tail is padded
                pair_q.last      <= last_word;
                pair_q.hdr       <= cur_hdr;
                pair_q.src       <= SRC;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (hdr_now)
            cur_hdr <= word.hdr;
        if (waiting && slot_ok)
            cur_slot <= slot_id;
        if (pay_now && !cnt[0])
            lo_q <= word.raw;
        if (push)
            fifo[wr_ptr] <= push_req;
    end

    // staging fifo, drained by arbiter grants
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 2'd1;
            if (gnt)
                rd_ptr <= rd_ptr + 2'd1;
            fifo_cnt <= fifo_cnt + 3'(push) - 3'(gnt);
        end
    end

    assign req = (fifo_cnt != 3'd0);

    always_comb
    begin
        wr       = fifo[rd_ptr];
        wr.valid = req;
    end

    a_gnt_needs_req: assert property (@(posedge clk) disable iff (!rst_n) gnt |-> req);

    // the slot answer must be back before the first entry is staged
    a_slot_in_time: assert property (@(posedge clk) disable iff (!rst_n)
        pair_q.valid |-> (!waiting || slot_ok || deny_now));

endmodule

// ==== src/port_switch_top.sv ====
`timescale 1ns/1ps

module port_switch_top #(
    parameter int NUM_PORTS    = switch_pkg::NUM_PORTS,
    parameter int NUM_SLOTS    = switch_pkg::NUM_SLOTS,
    parameter int SLOT_ENTRIES = switch_pkg::SLOT_ENTRIES
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [NUM_PORTS-1:0]          wr_sop,
    input  logic [NUM_PORTS-1:0]          wr_eop,
    input  logic [NUM_PORTS-1:0]          wr_vld,
    input  logic [NUM_PORTS-1:0][15:0]    wr_data,
    input  logic                          xfer_stop,
    output logic [15:0]                   data,
    output logic [3:0]                    dest_port,
    output logic [8:0]                    length,
    output logic [2:0]                    prio,
    output logic [switch_pkg::PORT_W-1:0] src_port,
    output logic                          data_vld,
    output logic                          sop_out,
    output logic                          eop_out,
    output logic [NUM_PORTS-1:0][7:0]     drop_cnt
);

    logic [NUM_PORTS-1:0]           slot_req;
    logic [NUM_PORTS-1:0]           slot_ok;
    logic [switch_pkg::SLOT_W-1:0]  slot_id;
    logic [NUM_PORTS-1:0]           req;
    logic [NUM_PORTS-1:0]           gnt;
    switch_pkg::wr_req_t            port_wr [NUM_PORTS];
    switch_pkg::wr_req_t            arb_wr;
    switch_pkg::desc_t              desc;
    logic                           desc_pop;
    logic                           desc_empty;
    logic [switch_pkg::SLOT_W-1:0]  rd_slot;
    logic [switch_pkg::ENTRY_W-1:0] rd_entry;
    logic [31:0]                    rd_data;
    logic                           slot_free;
    logic [switch_pkg::SLOT_W-1:0]  slot_free_id;

    for (genvar i = 0; i < NUM_PORTS; i++)
    begin : g_port
        port_rx #(.PORT_ID(i)) u_port_rx (
            .clk      (clk),
            .rst_n    (rst_n),
            .wr_sop   (wr_sop[i]),
            .wr_eop   (wr_eop[i]),
            .wr_vld   (wr_vld[i]),
            .wr_data  (wr_data[i]),
            .slot_req (slot_req[i]),
            .slot_ok  (slot_ok[i]),
            .slot_id  (slot_id),
            .req      (req[i]),
            .wr       (port_wr[i]),
            .gnt      (gnt[i]),
            .drop_cnt (drop_cnt[i])
        );
    end

    buf_arbiter #(.NUM_PORTS(NUM_PORTS)) u_arbiter (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (req),
        .wr_in  (port_wr),
        .gnt    (gnt),
        .wr_out (arb_wr)
    );

    packet_buffer #(.NUM_SLOTS(NUM_SLOTS), .SLOT_ENTRIES(SLOT_ENTRIES)) u_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .slot_req     (slot_req),
        .slot_ok      (slot_ok),
        .slot_id      (slot_id),
        .wr           (arb_wr),
        .desc_pop     (desc_pop),
        .desc         (desc),
        .desc_empty   (desc_empty),
        .rd_slot      (rd_slot),
        .rd_entry     (rd_entry),
        .rd_data      (rd_data),
        .slot_free    (slot_free),
        .slot_free_id (slot_free_id)
    );

    packet_reader #(.NUM_SLOTS(NUM_SLOTS), .SLOT_ENTRIES(SLOT_ENTRIES)) u_reader (
        .clk          (clk),
        .rst_n        (rst_n),
        .desc_empty   (desc_empty),
        .desc         (desc),
        .desc_pop     (desc_pop),
        .rd_slot      (rd_slot),
        .rd_entry     (rd_entry),
        .rd_data      (rd_data),
        .slot_free    (slot_free),
        .slot_free_id (slot_free_id),
        .xfer_stop    (xfer_stop),
        .data         (data),
        .dest_port    (dest_port),
        .length       (length),
        .prio         (prio),
        .src_port     (src_port),
        .data_vld     (data_vld),
        .sop_out      (sop_out),
        .eop_out      (eop_out)
    );

endmodule

// ==== src/switch_pkg.sv ====
package switch_pkg;

    parameter int NUM_PORTS    = 2;
    parameter int NUM_SLOTS    = 8;
    parameter int SLOT_ENTRIES = 16;                  // 32-bit entries, 32 payload words max

    parameter int SLOT_W  = $clog2(NUM_SLOTS);
    parameter int ENTRY_W = $clog2(SLOT_ENTRIES);
    parameter int PORT_W  = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

    typedef struct packed {
        logic [8:0] length;                           // payload words
        logic [2:0] prio;
        logic [3:0] dest;
    } hdr_t;

    // first word of a packet is a header, the rest are raw payload
    typedef union packed {
        hdr_t        hdr;
        logic [15:0] raw;
    } rx_word_u;

    typedef struct packed {
        logic               valid;
        logic [SLOT_W-1:0]  slot;
        logic [ENTRY_W-1:0] entry;
        logic [31:0]        data;
        logic               last;
        logic               two_words;                // high half holds a word
        hdr_t               hdr;
        logic [PORT_W-1:0]  src;
    } wr_req_t;

    typedef struct packed {
        logic [SLOT_W-1:0] slot;
        hdr_t              hdr;
        logic [PORT_W-1:0] src;
    } desc_t;

endpackage

// ==== tb/packet_patterns.txt ====
# phase port dest prio length payload_base(hex)
# payload word k of a packet is payload_base + k
1 0 3 1 1 1000
1 0 5 2 2 1100
1 0 9 7 31 1200
1 0 12 0 32 1300
2 0 1 3 5 2000
2 1 2 4 7 2100
2 0 6 5 16 2200
2 1 14 6 20 2300
3 0 7 2 12 3000
3 1 4 1 25 3100
4 0 1 0 6 4000
4 1 8 3 4 4100
4 0 2 1 3 4200
4 1 9 4 8 4300
4 0 3 2 9 4400
4 1 10 5 5 4500
4 0 4 6 4 4600
4 1 11 7 2 4700
4 0 5 0 2 4800
4 1 15 1 7 4900

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial
    begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;                                  // release just after an edge
    end

endmodule

// ==== tb/tb_port_switch.sv ====
`timescale 1ns/1ps

module tb_port_switch;

    localparam int NUM_PORTS    = 2;
    localparam int NUM_SLOTS    = 8;
    localparam int SLOT_ENTRIES = 16;
    localparam int MAX_PKTS     = 64;
    localparam int HOLD_PHASE   = 4;

    typedef struct packed {
        logic [3:0]  dest;
        logic [2:0]  prio;
        logic [8:0]  len;
        logic [15:0] base;
    } exp_pkt_t;

    logic                          clk;
    logic                          rst_n;
    logic [NUM_PORTS-1:0]          wr_sop;
    logic [NUM_PORTS-1:0]          wr_eop;
    logic [NUM_PORTS-1:0]          wr_vld;
    logic [NUM_PORTS-1:0][15:0]    wr_data;
    logic                          xfer_stop;
    logic [15:0]                   data;
    logic [3:0]                    dest_port;
    logic [8:0]                    length;
    logic [2:0]                    prio;
    logic [switch_pkg::PORT_W-1:0] src_port;
    logic                          data_vld;
    logic                          sop_out;
    logic                          eop_out;
    logic [NUM_PORTS-1:0][7:0]     drop_cnt;

    int       pk_phase [MAX_PKTS];
    int       pk_port  [MAX_PKTS];
    exp_pkt_t pk_info  [MAX_PKTS];
    int       hdr_cyc  [MAX_PKTS];
    exp_pkt_t exp_mem  [NUM_PORTS][MAX_PKTS];
    int       exp_wr   [NUM_PORTS];
    int       exp_rd   [NUM_PORTS];
    int       exp_drop [NUM_PORTS];
    int       n_pkts;
    int       errors;
    int       rx_count;
    int       cycle_cnt = 0;
    int       limit;
    bit       hold_mode;
    bit       stall_stop;
    bit       mon_active;
    int       widx;
    exp_pkt_t cur;
    string    test_name;

    tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(5)) u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    port_switch_top #(
        .NUM_PORTS    (NUM_PORTS),
        .NUM_SLOTS    (NUM_SLOTS),
        .SLOT_ENTRIES (SLOT_ENTRIES)
    ) dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_sop    (wr_sop),
        .wr_eop    (wr_eop),
        .wr_vld    (wr_vld),
        .wr_data   (wr_data),
        .xfer_stop (xfer_stop),
        .data      (data),
        .dest_port (dest_port),
        .length    (length),
        .prio      (prio),
        .src_port  (src_port),
        .data_vld  (data_vld),
        .sop_out   (sop_out),
        .eop_out   (eop_out),
        .drop_cnt  (drop_cnt)
    );

    always @(posedge clk)
        cycle_cnt <= cycle_cnt + 1;

    function automatic void report_value(string what, int exp, int act);
        errors++;
        $display("FAIL %s: %s expected %0h actual %0h", test_name, what, exp, act);
    endfunction

    function automatic void report_error(string msg);
        errors++;
        $display("ERROR %s: %s", test_name, msg);
    endfunction

    function automatic bit load_patterns();
        int    fd;
        int    n;
        int    ph;
        int    port;
        int    dest;
        int    pr;
        int    len;
        int    base;
        int    total;
        string line;
        fd = $fopen("tb/packet_patterns.txt", "r");
        if (fd == 0)
            return 1'b0;
        n_pkts = 0;
        total  = 2000;
        while (!$feof(fd))
        begin
            line = "";
            if ($fgets(line, fd) > 0 && line.getc(0) != "#")
            begin
                n = $sscanf(line, "%d %d %d %d %d %h", ph, port, dest, pr, len, base);
                if (n == 6 && (len < 1 || len > 2 * SLOT_ENTRIES))
                    report_error("pattern line with a length out of range");
                else if (n == 6 && n_pkts < MAX_PKTS)
                begin
                    pk_phase[n_pkts]     = ph;
                    pk_port[n_pkts]      = port;
                    pk_info[n_pkts].dest = 4'(dest);
                    pk_info[n_pkts].prio = 3'(pr);
                    pk_info[n_pkts].len  = 9'(len);
                    pk_info[n_pkts].base = 16'(base);
                    total += len + 10;
                    n_pkts++;
                end
            end
        end
        $fclose(fd);
        limit = total;
        return (n_pkts > 0);
    endfunction

    function automatic void push_expected(int i);
        int p;
        p = pk_port[i];
        if (exp_wr[p] < MAX_PKTS)
        begin
            exp_mem[p][exp_wr[p]] = pk_info[i];
            exp_wr[p]++;
        end
    endfunction

    function automatic int pending_count();
        int sum;
        sum = 0;
        for (int p = 0; p < NUM_PORTS; p++)
            sum += exp_wr[p] - exp_rd[p];
        return sum;
    endfunction

    task automatic send_packet(input int i);
        int       p;
        exp_pkt_t pkt;
        p   = pk_port[i];
        pkt = pk_info[i];
        @(posedge clk);
        #1;
        hdr_cyc[i] = cycle_cnt;
        if (!hold_mode)
            push_expected(i);
        wr_sop[p]  = 1'b1;
        wr_vld[p]  = 1'b1;
        wr_data[p] = {pkt.len, pkt.prio, pkt.dest};      // header word
        for (int k = 0; k < int'(pkt.len); k++)
        begin
            @(posedge clk);
            #1;
            wr_sop[p]  = 1'b0;
            wr_data[p] = pkt.base + 16'(k);
            wr_eop[p]  = (k == int'(pkt.len) - 1);
        end
        @(posedge clk);
        #1;
        wr_vld[p]  = 1'b0;
        wr_eop[p]  = 1'b0;
        wr_data[p] = '0;
        repeat (2) @(posedge clk);                       // 3 idle cycles after eop
    endtask

    task automatic send_port(input int p, input int ph);
        for (int i = 0; i < n_pkts; i++)
            if (pk_phase[i] == ph && pk_port[i] == p)
                send_packet(i);
    endtask

    task automatic drive_phase(input int ph);
        fork
            send_port(0, ph);
            send_port(1, ph);
        join
    endtask

    task automatic wait_drain();
        while (pending_count() != 0 || mon_active)
            @(posedge clk);
        repeat (4) @(posedge clk);
        #1;
    endtask

    task automatic random_stalls();
        int run_len;
        int stop_len;
        while (!stall_stop)
        begin
            run_len  = 1 + int'($urandom % 8);
            stop_len = 1 + int'($urandom % 8);
            for (int i = 0; i < run_len && !stall_stop; i++)
            begin
                @(posedge clk);
                #1 xfer_stop = 1'b0;
            end
            for (int i = 0; i < stop_len && !stall_stop; i++)
            begin
                @(posedge clk);
                #1 xfer_stop = 1'b1;
            end
        end
        xfer_stop = 1'b0;
    endtask

    // slots go out in header order, lower port first on a tie
    function automatic void settle_hold_phase();
        int rank;
        for (int i = 0; i < n_pkts; i++)
        begin
            if (pk_phase[i] == HOLD_PHASE)
            begin
                rank = 0;
                for (int j = 0; j < n_pkts; j++)
                    if (pk_phase[j] == HOLD_PHASE && (hdr_cyc[j] < hdr_cyc[i] ||
                        (hdr_cyc[j] == hdr_cyc[i] && pk_port[j] < pk_port[i])))
                        rank++;
                if (rank < NUM_SLOTS)
                    push_expected(i);
                else
                    exp_drop[pk_port[i]]++;
            end
        end
    endfunction

    task automatic check_drops();
        for (int p = 0; p < NUM_PORTS; p++)
            if (int'(drop_cnt[p]) != exp_drop[p])
                report_value($sformatf("drop_cnt[%0d]", p), exp_drop[p], drop_cnt[p]);
    endtask

    task automatic run_tests();
        int base_rx;
        test_name = "reset";
        @(negedge clk);
        if (data_vld || sop_out || eop_out)
            report_error("reader strobes active during reset");
        wait (rst_n === 1'b1);
        @(negedge clk);
        if (data_vld || sop_out || eop_out)
            report_error("reader strobes active after reset");
        check_drops();

        test_name = "single_port";
        drive_phase(1);
        wait_drain();
        check_drops();

        test_name = "two_ports";
        drive_phase(2);
        wait_drain();
        check_drops();

        test_name  = "random_stall";
        stall_stop = 1'b0;
        fork
            begin
                drive_phase(3);
                wait_drain();
                stall_stop = 1'b1;
            end
            random_stalls();
        join
        check_drops();

        test_name = "hold_overflow";
        base_rx   = rx_count;
        @(posedge clk);
        #1;
        xfer_stop = 1'b1;
        hold_mode = 1'b1;
        drive_phase(HOLD_PHASE);
        repeat (10) @(posedge clk);
        #1;
        settle_hold_phase();
        check_drops();
        if (rx_count != base_rx)
            report_value("packets out while stalled", 0, rx_count - base_rx);
        xfer_stop = 1'b0;
        hold_mode = 1'b0;
        wait_drain();
        if (rx_count - base_rx != NUM_SLOTS)
            report_value("packets stored", NUM_SLOTS, rx_count - base_rx);
        check_drops();
    endtask

    // output monitor, sampled mid-cycle
    always @(negedge clk)
    begin
        if (rst_n)
        begin
            if ((sop_out || eop_out) && !data_vld)
                report_error("sop_out or eop_out without data_vld");
            if (data_vld && xfer_stop)
                report_error("data_vld high while xfer_stop is high");
            if (data_vld && sop_out)
            begin
                rx_count++;
                if (mon_active)
                    report_error("sop_out inside a packet");
                if (exp_rd[src_port] == exp_wr[src_port])
                begin
                    report_error($sformatf("packet from source %0d was not expected", src_port));
                    mon_active = 1'b0;
                end
                else
                begin
                    cur = exp_mem[src_port][exp_rd[src_port]];
                    exp_rd[src_port]++;
                    mon_active = 1'b1;
                    widx       = 0;
                    if (dest_port != cur.dest)
                        report_value("dest_port", cur.dest, dest_port);
                    if (length != cur.len)
                        report_value("length", cur.len, length);
                    if (prio != cur.prio)
                        report_value("prio", cur.prio, prio);
                end
            end
            if (data_vld && mon_active)
            begin
                if (data != 16'(cur.base + widx))
                    report_value($sformatf("data word %0d", widx), 16'(cur.base + widx), data);
                if (eop_out)
                begin
                    if (widx != int'(cur.len) - 1)
                        report_value("eop position", int'(cur.len) - 1, widx);
                    mon_active = 1'b0;
                end
                else if (widx >= int'(cur.len) - 1)
                begin
                    report_error("packet ran past its length without eop_out");
                    mon_active = 1'b0;
                end
                widx++;
            end
            else if (data_vld)
                report_error("data_vld outside a packet");
        end
    end

    initial
    begin : watchdog
        wait (limit > 0);
        while (cycle_cnt < limit)
            @(posedge clk);
        $display("timeout: run passed the limit of %0d cycles, %0d errors so far", limit, errors);
        $display("Test failures found");
        $finish;
    end

    initial
    begin : main
        wr_sop     = '0;
        wr_eop     = '0;
        wr_vld     = '0;
        wr_data    = '0;
        xfer_stop  = 1'b0;
        errors     = 0;
        rx_count   = 0;
        limit      = 0;
        hold_mode  = 1'b0;
        stall_stop = 1'b1;
        mon_active = 1'b0;
        widx       = 0;
        test_name  = "setup";
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            exp_wr[p]   = 0;
            exp_rd[p]   = 0;
            exp_drop[p] = 0;
        end
        void'($urandom(32'hacd4));
        if (!load_patterns())
        begin
            $display("could not read any packet from tb/packet_patterns.txt");
            $display("Test failures found");
            $finish;
        end
        else
        begin
            run_tests();
            $display("summary: %0d errors, %0d packets checked", errors, rx_count);
            if (errors == 0)
                $display("All tests passed!");
            else
                $display("Test failures found");
            $finish;
        end
    end

endmodule
